// File: common/owt_cfg.svh
`ifndef OWT_CFG_SVH
`define OWT_CFG_SVH

// ============================================================
// field widths
// ============================================================
`define OWT_ADDR_W      7
`define OWT_DATA_W      8
// write flag on top of the address
`define OWT_CMD_W       (`OWT_ADDR_W + 1)
`define OWT_CRC_W       8

// frame layout, in symbols
`define OWT_SYNC_BITS   4
`define OWT_TAIL_BITS   4

// clock cycles per half-bit on the wire
`define OWT_HALF_CYC    12

// crc-8, init value zero
`define OWT_CRC_POLY    8'h07

// register read by every watchdog frame
`define OWT_ADC_ADDR    7'h7F

`endif

// File: common/owt_pkg.sv
`default_nettype none

`include "owt_cfg.svh"

package owt_pkg;

    typedef logic [`OWT_ADDR_W-1:0] owt_addr_t;
    typedef logic [`OWT_DATA_W-1:0] owt_data_t;
    // msb set means write
    typedef logic [`OWT_CMD_W-1:0]  owt_cmd_t;
    typedef logic [`OWT_CRC_W-1:0]  owt_crc_t;

    typedef logic [3:0] owt_cnt_t;
    typedef logic [$clog2(`OWT_HALF_CYC)-1:0] owt_half_cnt_t;

    typedef enum logic [2:0] {
        st_idle,
        st_sync_head,
        st_sync_tail,
        st_cmd,
        st_data,
        st_crc,
        st_end_tail
    } owt_seq_st_e;

endpackage

`default_nettype wire

// File: common/owt_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one granted frame, arbiter to sequencer
interface owt_req_if import owt_pkg::*; ();

    logic      start;
    owt_cmd_t  cmd;
    logic      has_data;
    owt_data_t data;
    logic      busy;

    modport arb (output start, output cmd, output has_data, output data, input busy);

    modport seq (input start, input cmd, input has_data, input data, output busy);

endinterface

`default_nettype wire

// File: common/owt_sym_if.sv
`timescale 1ns/1ps
`default_nettype none

// one symbol at a time, sequencer to line encoder
interface owt_sym_if ();

    logic vld;
    logic level;
    // high: manchester bit, low: one raw half-period
    logic mcst;
    logic done;

    modport seq (output vld, output level, output mcst, input done);

    modport enc (input vld, input level, input mcst, output done);

endinterface

`default_nettype wire

// File: owt_frame/owt_crc8.sv
`timescale 1ns/1ps
`default_nettype none

`include "owt_cfg.svh"

module owt_crc8 import owt_pkg::*; (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_clear,
    input  wire logic i_bit_vld,
    input  wire logic i_bit,
    output owt_crc_t  o_crc
);

    owt_crc_t crc_q;
    logic     fb;

    // serial lfsr, msb first
    assign fb = crc_q[`OWT_CRC_W-1] ^ i_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_bit_vld) begin
            crc_q <= {crc_q[`OWT_CRC_W-2:0], 1'b0} ^ (fb ? owt_crc_t'(`OWT_CRC_POLY) : '0);
        end
    end

    assign o_crc = crc_q;

endmodule

`default_nettype wire

// File: owt_frame/owt_frame_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "owt_cfg.svh"

module owt_frame_seq import owt_pkg::*; (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    owt_req_if.seq    req_if,
    owt_sym_if.seq    sym_if,
    output owt_cmd_t  o_last_cmd
);

    localparam int FIELD_IDX_W = $clog2(`OWT_CMD_W);
    localparam int TAIL_IDX_W  = $clog2(`OWT_TAIL_BITS);
    // high, high, low, low
    localparam logic [`OWT_TAIL_BITS-1:0] TAIL_PAT = 4'b1100;

    owt_seq_st_e st_q;
    owt_seq_st_e st_d;
    owt_cnt_t    bit_cnt;
    owt_cnt_t    field_last;
    owt_cnt_t    bit_idx;
    logic        cur_bit;
    logic        field_end;
    logic        crc_bit_vld;
    owt_crc_t    crc;

    // ============================================================
    // field length and current bit
    // ============================================================
    always_comb begin
        unique case (st_q)
            st_sync_head: field_last = owt_cnt_t'(`OWT_SYNC_BITS - 1);
            st_sync_tail: field_last = owt_cnt_t'(`OWT_TAIL_BITS - 1);
            st_cmd:       field_last = owt_cnt_t'(`OWT_CMD_W - 1);
            st_data:      field_last = owt_cnt_t'(`OWT_DATA_W - 1);
            st_crc:       field_last = owt_cnt_t'(`OWT_CRC_W - 1);
            st_end_tail:  field_last = owt_cnt_t'(`OWT_TAIL_BITS - 1);
            default:      field_last = '0;
        endcase
    end

    // msb first
    assign bit_idx = field_last - bit_cnt;

    always_comb begin
        unique case (st_q)
            st_sync_tail: cur_bit = TAIL_PAT[bit_idx[TAIL_IDX_W-1:0]];
            st_cmd:       cur_bit = req_if.cmd[bit_idx[FIELD_IDX_W-1:0]];
            st_data:      cur_bit = req_if.data[bit_idx[FIELD_IDX_W-1:0]];
            st_crc:       cur_bit = crc[bit_idx[FIELD_IDX_W-1:0]];
            st_end_tail:  cur_bit = TAIL_PAT[bit_idx[TAIL_IDX_W-1:0]];
            // sync head is all zeros
            default:      cur_bit = 1'b0;
        endcase
    end

    assign field_end = sym_if.done & (bit_cnt == field_last);

    // ============================================================
    // frame FSM
    // ============================================================
    always_comb begin
        st_d = st_q;
        unique case (st_q)
            st_idle: begin
                if (req_if.start) begin
                    st_d = st_sync_head;
                end
            end
            st_sync_head: begin
                if (field_end) begin
                    st_d = st_sync_tail;
                end
            end
            st_sync_tail: begin
                if (field_end) begin
                    st_d = st_cmd;
                end
            end
            st_cmd: begin
                if (field_end) begin
                    // watchdog frames carry no data field
                    st_d = req_if.has_data ? st_data : st_crc;
                end
            end
            st_data: begin
                if (field_end) begin
                    st_d = st_crc;
                end
            end
            st_crc: begin
                if (field_end) begin
                    st_d = st_end_tail;
                end
            end
            st_end_tail: begin
                if (field_end) begin
                    st_d = st_idle;
                end
            end
            default: st_d = st_idle;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            st_q    <= st_idle;
            bit_cnt <= '0;
        end else begin
            st_q <= st_d;
            if (sym_if.done) begin
                bit_cnt <= field_end ? '0 : bit_cnt + owt_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_last_cmd <= '0;
        end else if (field_end && st_q == st_end_tail) begin
            o_last_cmd <= req_if.cmd;
        end
    end

    // ============================================================
    // symbol out and crc feed
    // ============================================================
    assign sym_if.vld   = (st_q != st_idle);
    assign sym_if.level = cur_bit;
    assign sym_if.mcst  = (st_q == st_sync_head) | (st_q == st_cmd) |
                          (st_q == st_data) | (st_q == st_crc);
    assign req_if.busy  = (st_q != st_idle);

    assign crc_bit_vld = sym_if.done & ((st_q == st_cmd) | (st_q == st_data));

    owt_crc8 u_crc8 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (req_if.start),
        .i_bit_vld (crc_bit_vld),
        .i_bit     (cur_bit),
        .o_crc     (crc)
    );

endmodule

`default_nettype wire

// File: src/owt_tx_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "owt_cfg.svh"

module owt_tx_arb import owt_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_spi_owt_wr_req,
    input  wire logic      i_spi_owt_rd_req,
    input  wire owt_addr_t i_spi_owt_addr,
    input  wire owt_data_t i_spi_owt_data,
    input  wire logic      i_wdg_owt_adc_req,
    output logic           o_owt_spi_ack,
    output logic           o_owt_wdg_adc_ack,
    owt_req_if.arb         req_if
);

    logic spi_req;
    logic grant_ok;
    logic spi_grant;
    logic wdg_grant;

    assign spi_req   = i_spi_owt_wr_req | i_spi_owt_rd_req;
    // no new grant while a frame runs or one is being handed over
    assign grant_ok  = ~req_if.busy & ~req_if.start;
    assign spi_grant = grant_ok & spi_req;
    assign wdg_grant = grant_ok & ~spi_req & i_wdg_owt_adc_req;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_owt_spi_ack     <= 1'b0;
            o_owt_wdg_adc_ack <= 1'b0;
            req_if.has_data   <= 1'b0;
        end else begin
            o_owt_spi_ack     <= spi_grant;
            o_owt_wdg_adc_ack <= wdg_grant;
            if (spi_grant | wdg_grant) begin
                req_if.has_data <= spi_grant;
            end
        end
    end

    // frame payload, captured at grant
    always_ff @(posedge i_clk) begin
        if (spi_grant) begin
            // a read request wins over a write flag
            req_if.cmd  <= {~i_spi_owt_rd_req, i_spi_owt_addr};
            req_if.data <= i_spi_owt_data;
        end else if (wdg_grant) begin
            req_if.cmd  <= {1'b0, owt_addr_t'(`OWT_ADC_ADDR)};
        end
    end

    assign req_if.start = o_owt_spi_ack | o_owt_wdg_adc_ack;

endmodule

`default_nettype wire

// File: src/owt_line_enc.sv
`timescale 1ns/1ps
`default_nettype none

`include "owt_cfg.svh"

module owt_line_enc import owt_pkg::*; (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    owt_sym_if.enc    sym_if,
    output logic      o_line
);

    localparam owt_half_cnt_t HALF_LAST = owt_half_cnt_t'(`OWT_HALF_CYC - 1);

    owt_half_cnt_t half_cnt;
    // second half of a manchester bit
    logic          phase;
    logic          half_end;

    assign half_end    = sym_if.vld & (half_cnt == HALF_LAST);
    assign sym_if.done = half_end & (~sym_if.mcst | phase);

    // ============================================================
    // half-bit stretch
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            half_cnt <= '0;
            phase    <= 1'b0;
        end else if (!sym_if.vld) begin
            half_cnt <= '0;
            phase    <= 1'b0;
        end else if (half_end) begin
            half_cnt <= '0;
            phase    <= sym_if.mcst & ~phase;
        end else begin
            half_cnt <= half_cnt + owt_half_cnt_t'(1);
        end
    end

    // manchester 1 is high then low, 0 is low then high
    // idle line stays high
    assign o_line = sym_if.vld ? (sym_if.level ^ (sym_if.mcst & phase)) : 1'b1;

endmodule

`default_nettype wire

// File: src/owt_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module owt_tx_top import owt_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,

    input  wire logic      i_spi_owt_wr_req,
    input  wire logic      i_spi_owt_rd_req,
    input  wire owt_addr_t i_spi_owt_addr,
    input  wire owt_data_t i_spi_owt_data,
    output logic           o_owt_spi_ack,

    input  wire logic      i_wdg_owt_adc_req,
    output logic           o_owt_wdg_adc_ack,

    output logic           o_lv_hv_owt_tx,
    output owt_cmd_t       o_owt_last_tx_cmd
);

    owt_req_if u_req_if ();
    owt_sym_if u_sym_if ();

    owt_tx_arb u_arb (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_spi_owt_wr_req  (i_spi_owt_wr_req),
        .i_spi_owt_rd_req  (i_spi_owt_rd_req),
        .i_spi_owt_addr    (i_spi_owt_addr),
        .i_spi_owt_data    (i_spi_owt_data),
        .i_wdg_owt_adc_req (i_wdg_owt_adc_req),
        .o_owt_spi_ack     (o_owt_spi_ack),
        .o_owt_wdg_adc_ack (o_owt_wdg_adc_ack),
        .req_if            (u_req_if.arb)
    );

    owt_frame_seq u_frame_seq (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .req_if     (u_req_if.seq),
        .sym_if     (u_sym_if.seq),
        .o_last_cmd (o_owt_last_tx_cmd)
    );

    owt_line_enc u_line_enc (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .sym_if  (u_sym_if.enc),
        .o_line  (o_lv_hv_owt_tx)
    );

endmodule

`default_nettype wire

// File: dv/owt_tx_chk.sv
`timescale 1ns/1ps
`default_nettype none

module owt_tx_chk (
    input wire logic i_clk,
    input wire logic i_rst_n,
    input wire logic o_owt_spi_ack,
    input wire logic o_owt_wdg_adc_ack,
    input wire logic o_lv_hv_owt_tx
);

    // set by the first grant after reset
    logic seen_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            seen_ack <= 1'b0;
        end else if (o_owt_spi_ack || o_owt_wdg_adc_ack) begin
            seen_ack <= 1'b1;
        end
    end

    // ============================================================
    // handshake and idle line
    // ============================================================
    a_one_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_owt_spi_ack && o_owt_wdg_adc_ack))
        else $error("SPI and watchdog acknowledged together");

    a_spi_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_owt_spi_ack |=> !o_owt_spi_ack)
        else $error("SPI acknowledge longer than one cycle");

    a_wdg_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_owt_wdg_adc_ack |=> !o_owt_wdg_adc_ack)
        else $error("watchdog acknowledge longer than one cycle");

    a_idle_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !seen_ack |-> o_lv_hv_owt_tx)
        else $error("line left idle level before the first grant");

endmodule

`default_nettype wire

// File: dv/owt_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "owt_cfg.svh"

module owt_tx_tb;

    localparam int SEED       = 33866;
    localparam int ACK_LIMIT  = 64;
    localparam int EDGE_LIMIT = 64;

    logic                   i_clk = 1'b0;
    logic                   i_rst_n;
    logic                   i_spi_owt_wr_req;
    logic                   i_spi_owt_rd_req;
    logic [`OWT_ADDR_W-1:0] i_spi_owt_addr;
    logic [`OWT_DATA_W-1:0] i_spi_owt_data;
    logic                   o_owt_spi_ack;
    logic                   i_wdg_owt_adc_req;
    logic                   o_owt_wdg_adc_ack;
    logic                   o_lv_hv_owt_tx;
    logic [`OWT_CMD_W-1:0]  o_owt_last_tx_cmd;

    int errors = 0;
    int timeouts = 0;
    int frames = 0;
    int hold;
    bit timed_out = 1'b0;

    always #10 i_clk = ~i_clk;

    owt_tx_top i_dut (.*);

    bind owt_tx_top owt_tx_chk u_chk (.*);

    task automatic check_val(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    // ============================================================
    // line decoder
    // ============================================================
    task automatic sample_half(output logic lvl);
        repeat (hold) @(negedge i_clk);
        lvl = o_lv_hv_owt_tx;
        hold = `OWT_HALF_CYC;
    endtask

    task automatic read_field(input int n, input bit mcst, output logic [7:0] val);
        logic h0;
        logic h1;
        val = 8'h00;
        for (int i = 0; i < n; i++) begin
            sample_half(h0);
            if (mcst) begin
                sample_half(h1);
                check_val(8'(h1), 8'(!h0), "manchester second half");
            end
            val = {val[6:0], h0};
        end
    endtask

    task automatic decode_frame(input logic [7:0] exp_cmd, input bit has_data,
                                input logic [7:0] exp_data, input logic [7:0] exp_crc);
        int n;
        logic prev;
        logic [7:0] v;
        n = 0;
        prev = o_lv_hv_owt_tx;
        while (!(prev === 1'b1 && o_lv_hv_owt_tx === 1'b0) && n < EDGE_LIMIT) begin
            prev = o_lv_hv_owt_tx;
            @(negedge i_clk);
            n++;
        end
        if (!(prev === 1'b1 && o_lv_hv_owt_tx === 1'b0)) begin
            timed_out = 1'b1;
            timeouts++;
            $display("timeout: no frame start seen on the line at %0t", $time);
        end else begin
            // first sample lands mid-half
            hold = `OWT_HALF_CYC / 2;
            read_field(`OWT_SYNC_BITS, 1'b1, v);
            check_val(v, 8'h00, "sync head");
            read_field(`OWT_TAIL_BITS, 1'b0, v);
            check_val(v, 8'h0C, "sync tail");
            read_field(`OWT_CMD_W, 1'b1, v);
            check_val(v, exp_cmd, "command");
            if (has_data) begin
                read_field(`OWT_DATA_W, 1'b1, v);
                check_val(v, exp_data, "data");
            end
            read_field(`OWT_CRC_W, 1'b1, v);
            check_val(v, exp_crc, "crc");
            read_field(`OWT_TAIL_BITS, 1'b0, v);
            check_val(v, 8'h0C, "end tail");
            repeat (`OWT_HALF_CYC / 2) @(negedge i_clk);
            check_val(8'(o_lv_hv_owt_tx), 8'h01, "idle line after frame");
            check_val(o_owt_last_tx_cmd, exp_cmd, "last command");
            frames++;
        end
    endtask

    // ============================================================
    // request handshake
    // ============================================================
    task automatic wait_ack(input bit wdg);
        int n;
        n = 0;
        while ((wdg ? o_owt_wdg_adc_ack : o_owt_spi_ack) !== 1'b1 && n < ACK_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if ((wdg ? o_owt_wdg_adc_ack : o_owt_spi_ack) !== 1'b1) begin
            timed_out = 1'b1;
            timeouts++;
            $display("timeout: %s request never acknowledged at %0t",
                     wdg ? "watchdog" : "SPI", $time);
        end else begin
            check_val(8'(wdg ? o_owt_spi_ack : o_owt_wdg_adc_ack), 8'h00, "other ack");
        end
    endtask

    // client 0 is SPI, 1 watchdog, 2 both raised in one cycle
    task automatic run_request(input int client, input logic rw, input logic [7:0] addr,
                               input logic [7:0] data, input logic [7:0] crc,
                               input logic [7:0] wcrc);
        if (client != 1) begin
            i_spi_owt_wr_req = rw;
            i_spi_owt_rd_req = ~rw;
            i_spi_owt_addr   = addr[`OWT_ADDR_W-1:0];
            i_spi_owt_data   = data;
        end
        if (client != 0) begin
            i_wdg_owt_adc_req = 1'b1;
        end
        if (client != 1 && !timed_out) begin
            wait_ack(1'b0);
            i_spi_owt_wr_req = 1'b0;
            i_spi_owt_rd_req = 1'b0;
            if (!timed_out) begin
                decode_frame({rw, addr[`OWT_ADDR_W-1:0]}, 1'b1, data, crc);
            end
        end
        if (client != 0 && !timed_out) begin
            wait_ack(1'b1);
            i_wdg_owt_adc_req = 1'b0;
            if (!timed_out) begin
                decode_frame({1'b0, `OWT_ADC_ADDR}, 1'b0, 8'h00, wcrc);
            end
        end
        i_spi_owt_wr_req  = 1'b0;
        i_spi_owt_rd_req  = 1'b0;
        i_wdg_owt_adc_req = 1'b0;
    endtask

    initial begin
        int fd;
        int n;
        int gap;
        int client;
        string line;
        logic [7:0] rw;
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] crc;
        logic [7:0] wcrc;

        i_rst_n           = 1'b0;
        i_spi_owt_wr_req  = 1'b0;
        i_spi_owt_rd_req  = 1'b0;
        i_spi_owt_addr    = '0;
        i_spi_owt_data    = '0;
        i_wdg_owt_adc_req = 1'b0;
        void'($urandom(SEED));

        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_val(8'(o_owt_spi_ack), 8'h00, "SPI ack after reset");
        check_val(8'(o_owt_wdg_adc_ack), 8'h00, "watchdog ack after reset");
        check_val(8'(o_lv_hv_owt_tx), 8'h01, "line after reset");
        check_val(o_owt_last_tx_cmd, 8'h00, "last command after reset");

        fd = $fopen("dv/owt_tx_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file dv/owt_tx_input.txt");
        end else begin
            while (!timed_out && !$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "/") begin
                    n = $sscanf(line, "%d %h %h %h %h %h", client, rw, addr, data, crc, wcrc);
                    if (n != 6) begin
                        errors++;
                        $display("stimulus line could not be parsed: %s", line);
                    end else begin
                        gap = 2 + int'($urandom % 16);
                        repeat (gap) @(negedge i_clk);
                        run_request(client, rw[0], addr, data, crc, wcrc);
                    end
                end
            end
            $fclose(fd);
        end
        if (frames == 0) begin
            errors++;
            $display("no frame was decoded during the run");
        end

        $display("frames %0d, errors %0d, timeouts %0d", frames, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/owt_tx_input.txt
// client rw addr data crc wcrc, client decimal, others hex
// client 0 SPI, 1 watchdog, 2 SPI and watchdog raised in the same cycle
0 1 15 a5 d2 00
0 0 2a 3c 98 00
1 0 00 00 00 7a
2 1 7f 00 d7 7a
0 0 00 ff f3 00
0 1 01 80 2a 00
1 0 00 00 00 7a
2 0 55 5a cc 7a

// File: vlog.f
+incdir+common
common/owt_pkg.sv
common/owt_req_if.sv
common/owt_sym_if.sv
owt_frame/owt_crc8.sv
owt_frame/owt_frame_seq.sv
src/owt_tx_arb.sv
src/owt_line_enc.sv
src/owt_tx_top.sv
dv/owt_tx_chk.sv
dv/owt_tx_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module owt_tx_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vowt_tx_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
